// File: verilog/bp_pkg.sv
`default_nettype none

package bp_pkg;

  localparam int num_lanes   = 2;
  localparam int bh_idx_bits = 4;
  localparam int bh_entries  = 2 ** bh_idx_bits;

  typedef logic [31:0]            pc_t;
  typedef logic [31:0]            inst_t;
  typedef logic [5:0]             opcode_t;
  typedef logic [4:0]             rob_idx_t;  // 32 ROB entries
  typedef logic [4:0]             fl_idx_t;
  typedef logic [2:0]             lsq_idx_t;
  typedef logic [bh_idx_bits-1:0] bh_idx_t;
  typedef logic [1:0]             counter_t;

  localparam counter_t bht_reset_value = 2'b01; // weakly not taken
  localparam pc_t      btb_reset_value = 32'h0;
  localparam pc_t      inst_bytes      = 32'd4;

  // conditional branches
  localparam opcode_t blbc_op = 6'h38;
  localparam opcode_t beq_op  = 6'h39;
  localparam opcode_t blt_op  = 6'h3a;
  localparam opcode_t ble_op  = 6'h3b;
  localparam opcode_t blbs_op = 6'h3c;
  localparam opcode_t bne_op  = 6'h3d;
  localparam opcode_t bge_op  = 6'h3e;
  localparam opcode_t bgt_op  = 6'h3f;

  // unconditional
  localparam opcode_t br_op  = 6'h30;
  localparam opcode_t bsr_op = 6'h34;
  localparam opcode_t jsr_op = 6'h1a;

  typedef struct packed {
    logic  valid;
    pc_t   pc;
    inst_t inst;
  } fetch_lane_t;

  typedef struct packed {
    logic     done;
    logic     taken;
    pc_t      pc;
    pc_t      predicted_target;
    pc_t      actual_target;
    rob_idx_t rob_idx;
    fl_idx_t  fl_idx;
    lsq_idx_t sq_idx;
    lsq_idx_t lq_idx;
  } br_resolve_t;

  typedef struct packed {
    logic     violate;
    pc_t      restart_pc;
    rob_idx_t rob_idx;
    fl_idx_t  fl_idx;
    lsq_idx_t sq_idx;
    lsq_idx_t lq_idx;
  } ld_violate_t;

  typedef struct packed {
    logic     en;
    rob_idx_t rob_idx;
    fl_idx_t  fl_idx;
    lsq_idx_t sq_idx;
    lsq_idx_t lq_idx;
  } rollback_t;

  typedef struct packed {
    logic [num_lanes-1:0] lane_valid;
    logic [num_lanes-1:0] take_branch;
    pc_t                  target;
  } fetch_redirect_t;

  typedef struct packed {
    logic    en;
    bh_idx_t idx;
    pc_t     target;
  } btb_write_t;

  // word-aligned pc bits select the table entry
  function automatic bh_idx_t pc_to_idx(pc_t pc);
    return pc[bh_idx_bits+1:2];
  endfunction

endpackage

`default_nettype wire

// File: verilog/branch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module branch_decode import bp_pkg::*; (
  input  fetch_lane_t [num_lanes-1:0] lanes,
  input  logic                        rollback_en,
  output logic        [num_lanes-1:0] is_cond,
  output logic        [num_lanes-1:0] is_uncond
);

  opcode_t [num_lanes-1:0] opcode;

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      opcode[i] = lanes[i].inst[31:26];
    end
  end

  // fetched slots are ignored while a rollback flushes the front end
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      is_cond[i]   = 1'b0;
      is_uncond[i] = 1'b0;
      if (lanes[i].valid && !rollback_en) begin
        case (opcode[i])
          blbc_op,
          beq_op,
          blt_op,
          ble_op,
          blbs_op,
          bne_op,
          bge_op,
          bgt_op: begin
            is_cond[i] = 1'b1;
          end
          br_op,
          bsr_op,
          jsr_op: begin
            is_uncond[i] = 1'b1;
          end
          default: begin
            is_cond[i]   = 1'b0;  // not a branch
            is_uncond[i] = 1'b0;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/branch_history_table.sv
`timescale 1ns/1ps
`default_nettype none

module branch_history_table import bp_pkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  pc_t         [num_lanes-1:0] read_pc,
  output logic        [num_lanes-1:0] predict_taken,
  input  br_resolve_t [num_lanes-1:0] resolve
);

  counter_t [bh_entries-1:0] counters;
  counter_t [bh_entries-1:0] next_counters;

  // prediction sees the registered table only
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      predict_taken[i] = counters[pc_to_idx(read_pc[i])][1];
    end
  end

  // lanes applied in order, so lane 1 builds on lane 0 at a shared entry
  always_comb begin
    bh_idx_t  idx;
    counter_t cnt;
    next_counters = counters;
    for (int i = 0; i < num_lanes; i++) begin
      idx = pc_to_idx(resolve[i].pc);
      cnt = next_counters[idx];
      if (resolve[i].done) begin
        if (resolve[i].taken) begin
          if (cnt != 2'b11) begin
            cnt = cnt + 2'b01;
          end
        end else begin
          if (cnt != 2'b00) begin
            cnt = cnt - 2'b01;
          end
        end
        next_counters[idx] = cnt;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int e = 0; e < bh_entries; e++) begin
        counters[e] <= bht_reset_value;
      end
    end else begin
      counters <= next_counters;
    end
  end

endmodule

`default_nettype wire

// File: verilog/branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer import bp_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  pc_t    [num_lanes-1:0] read_pc,
  output pc_t    [num_lanes-1:0] predicted_target,
  input  btb_write_t             write
);

  pc_t [bh_entries-1:0] targets;

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      predicted_target[i] = targets[pc_to_idx(read_pc[i])];
    end
  end

  // the single write port carries the rollback winner
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int e = 0; e < bh_entries; e++) begin
        targets[e] <= btb_reset_value;
      end
    end else if (write.en) begin
      targets[write.idx] <= write.target;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rollback_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rollback_arbiter import bp_pkg::*; (
  input  br_resolve_t [num_lanes-1:0] resolve,
  input  ld_violate_t [num_lanes-1:0] violate,
  input  rob_idx_t                    rob_tail,
  output rollback_t                   rollback,
  output rob_idx_t                    rollback_distance,
  output pc_t                         restart_target,
  output btb_write_t                  btb_write
);

  pc_t      [num_lanes-1:0] br_next_pc;
  rob_idx_t [num_lanes-1:0] br_age;
  rob_idx_t [num_lanes-1:0] ld_age;
  logic     [num_lanes-1:0] br_req;
  logic     [num_lanes-1:0] ld_req;

  logic        br_any;
  logic        ld_any;
  logic        br_sel;   // lane of the oldest mispredicted branch
  logic        ld_sel;   // lane of the oldest violating load
  logic        br_wins;
  br_resolve_t br_win;
  ld_violate_t ld_win;

  // resolved next pc, misprediction and age per request
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      br_next_pc[i] = resolve[i].taken ? resolve[i].actual_target
                                       : resolve[i].pc + inst_bytes;
      br_req[i]     = resolve[i].done &&
                      (resolve[i].predicted_target != br_next_pc[i]);
      br_age[i]     = rob_tail - resolve[i].rob_idx; // wraps mod 32
      ld_req[i]     = violate[i].violate;
      ld_age[i]     = rob_tail - violate[i].rob_idx;
    end
  end

  assign br_any = |br_req;
  assign ld_any = |ld_req;

  // lane 0 keeps a tie
  always_comb begin
    case (br_req)
      2'b10:   br_sel = 1'b1;
      2'b11:   br_sel = br_age[1] > br_age[0];
      default: br_sel = 1'b0;
    endcase
  end

  always_comb begin
    case (ld_req)
      2'b10:   ld_sel = 1'b1;
      2'b11:   ld_sel = ld_age[1] > ld_age[0];
      default: ld_sel = 1'b0;
    endcase
  end

  assign br_win = resolve[br_sel];
  assign ld_win = violate[ld_sel];

  // branch keeps an age tie against the load
  assign br_wins = br_any && (!ld_any || (br_age[br_sel] >= ld_age[ld_sel]));

  always_comb begin
    rollback          = '0;
    rollback_distance = '0;
    restart_target    = '0;
    if (br_wins) begin
      rollback.en       = 1'b1;
      rollback.rob_idx  = br_win.rob_idx;
      rollback.fl_idx   = br_win.fl_idx;
      rollback.sq_idx   = br_win.sq_idx;
      rollback.lq_idx   = br_win.lq_idx;
      rollback_distance = br_age[br_sel];
      restart_target    = br_next_pc[br_sel];
    end else if (ld_any) begin
      rollback.en       = 1'b1;
      rollback.rob_idx  = ld_win.rob_idx;
      rollback.fl_idx   = ld_win.fl_idx;
      rollback.sq_idx   = ld_win.sq_idx;
      rollback.lq_idx   = ld_win.lq_idx;
      rollback_distance = ld_age[ld_sel];
      restart_target    = ld_win.restart_pc;
    end
  end

  // only a taken winner has a target worth keeping
  always_comb begin
    btb_write.en     = br_wins && br_win.taken;
    btb_write.idx    = pc_to_idx(br_win.pc);
    btb_write.target = br_win.actual_target;
  end

endmodule

`default_nettype wire

// File: verilog/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor import bp_pkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  fetch_lane_t [num_lanes-1:0] lanes,
  input  br_resolve_t [num_lanes-1:0] resolve,
  input  ld_violate_t [num_lanes-1:0] violate,
  input  rob_idx_t                    rob_tail,
  output fetch_redirect_t             redirect,
  output rollback_t                   rollback,
  output rob_idx_t                    rollback_distance
);

  pc_t        [num_lanes-1:0] lane_pc;
  pc_t        [num_lanes-1:0] btb_target;
  logic       [num_lanes-1:0] is_cond;
  logic       [num_lanes-1:0] is_uncond;
  logic       [num_lanes-1:0] bht_taken;
  logic       [num_lanes-1:0] take;
  pc_t                        restart_target;
  btb_write_t                 btb_write;

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      lane_pc[i] = lanes[i].pc;
      take[i]    = is_uncond[i] || (is_cond[i] && bht_taken[i]);
    end
  end

  branch_decode u_decode (
    .lanes       (lanes),
    .rollback_en (rollback.en),
    .is_cond     (is_cond),
    .is_uncond   (is_uncond)
  );

  branch_history_table u_bht (
    .clock         (clock),
    .reset         (reset),
    .read_pc       (lane_pc),
    .predict_taken (bht_taken),
    .resolve       (resolve)
  );

  branch_target_buffer u_btb (
    .clock            (clock),
    .reset            (reset),
    .read_pc          (lane_pc),
    .predicted_target (btb_target),
    .write            (btb_write)
  );

  rollback_arbiter u_arbiter (
    .resolve           (resolve),
    .violate           (violate),
    .rob_tail          (rob_tail),
    .rollback          (rollback),
    .rollback_distance (rollback_distance),
    .restart_target    (restart_target),
    .btb_write         (btb_write)
  );

  // a rollback squashes both slots and steers fetch to the restart pc
  always_comb begin
    if (rollback.en) begin
      redirect.lane_valid  = 2'b00;
      redirect.take_branch = 2'b11;
      redirect.target      = restart_target;
    end else begin
      redirect.lane_valid[0] = lanes[0].valid;
      redirect.lane_valid[1] = lanes[1].valid && !take[0]; // lane 1 is past a taken lane 0
      redirect.take_branch   = take;
      if (take[0]) begin
        redirect.target = btb_target[0];
      end else if (take[1]) begin
        redirect.target = btb_target[1];
      end else begin
        redirect.target = lanes[1].pc + inst_bytes;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/bp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bp_checker import bp_pkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  fetch_lane_t [num_lanes-1:0] lanes,
  input  br_resolve_t [num_lanes-1:0] resolve,
  input  ld_violate_t [num_lanes-1:0] violate,
  input  rob_idx_t                    rob_tail,
  input  fetch_redirect_t             redirect,
  input  rollback_t                   rollback,
  input  rob_idx_t                    rollback_distance,
  input  logic                        stim_done,
  output logic                        done,
  output int                          error_count
);

  counter_t bht [16];
  pc_t      btb [16];

  function automatic logic lane_taken(fetch_lane_t lane, counter_t cnt);
    return lane.valid && ((lane.inst[31:26] inside {br_op, bsr_op, jsr_op}) ||
           ((lane.inst[31:26] inside {blbc_op, beq_op, blt_op, ble_op,
                                      blbs_op, bne_op, bge_op, bgt_op}) && cnt[1]));
  endfunction

  // outputs settled since the falling edge and the model still holds last cycle's tables
  always @(posedge clock) begin
    fetch_redirect_t exp_redirect;
    rollback_t       exp_rollback;
    rob_idx_t        exp_distance;
    pc_t             exp_target;
    pc_t             next_pc [2];
    rob_idx_t        br_age [2];
    rob_idx_t        ld_age [2];
    logic            take [2];
    logic            br_found;
    logic            ld_found;
    logic            br_lane;
    logic            ld_lane;
    logic            br_first;
    logic [3:0]      idx;
    if (reset) begin
      for (int e = 0; e < 16; e++) begin
        bht[e] = 2'b01;
        btb[e] = '0;
      end
      done        = 1'b0;
      error_count = 0;
    end else begin
      br_found = 1'b0;
      ld_found = 1'b0;
      br_lane  = 1'b0;
      ld_lane  = 1'b0;
      for (int i = 0; i < 2; i++) begin
        next_pc[i] = resolve[i].taken ? resolve[i].actual_target : resolve[i].pc + 32'd4;
        br_age[i]  = rob_tail - resolve[i].rob_idx;
        ld_age[i]  = rob_tail - violate[i].rob_idx;
        take[i]    = lane_taken(lanes[i], bht[lanes[i].pc[5:2]]);
        if (resolve[i].done && resolve[i].predicted_target != next_pc[i] &&
            (!br_found || br_age[i] > br_age[br_lane])) begin
          br_found = 1'b1;
          br_lane  = (i == 1);
        end
        if (violate[i].violate && (!ld_found || ld_age[i] > ld_age[ld_lane])) begin
          ld_found = 1'b1;
          ld_lane  = (i == 1);
        end
      end
      br_first     = br_found && (!ld_found || br_age[br_lane] >= ld_age[ld_lane]);
      exp_rollback = '0;
      exp_distance = '0;
      exp_target   = '0;
      if (br_first) begin
        exp_rollback = {1'b1, resolve[br_lane].rob_idx, resolve[br_lane].fl_idx,
                        resolve[br_lane].sq_idx, resolve[br_lane].lq_idx};
        exp_distance = br_age[br_lane];
        exp_target   = next_pc[br_lane];
      end else if (ld_found) begin
        exp_rollback = {1'b1, violate[ld_lane].rob_idx, violate[ld_lane].fl_idx,
                        violate[ld_lane].sq_idx, violate[ld_lane].lq_idx};
        exp_distance = ld_age[ld_lane];
        exp_target   = violate[ld_lane].restart_pc;
      end
      if (exp_rollback.en) begin
        exp_redirect = {2'b00, 2'b11, exp_target};
      end else begin
        exp_redirect.lane_valid  = {lanes[1].valid && !take[0], lanes[0].valid};
        exp_redirect.take_branch = {take[1], take[0]};
        exp_redirect.target      = take[0] ? btb[lanes[0].pc[5:2]] :
                                   take[1] ? btb[lanes[1].pc[5:2]] : lanes[1].pc + 32'd4;
      end
      if (redirect !== exp_redirect) begin
        $display("Mismatch redirect: got %h expected %h", redirect, exp_redirect);
        error_count++;
      end
      if (rollback !== exp_rollback) begin
        $display("Mismatch rollback: got %h expected %h", rollback, exp_rollback);
        error_count++;
      end
      if (rollback_distance !== exp_distance) begin
        $display("Mismatch rollback_distance: got %h expected %h",
                 rollback_distance, exp_distance);
        error_count++;
      end
      for (int i = 0; i < 2; i++) begin  // lane 1 sees lane 0's result
        idx = resolve[i].pc[5:2];
        if (resolve[i].done && resolve[i].taken && bht[idx] != 2'b11) begin
          bht[idx] = bht[idx] + 2'b01;
        end else if (resolve[i].done && !resolve[i].taken && bht[idx] != 2'b00) begin
          bht[idx] = bht[idx] - 2'b01;
        end
      end
      if (br_first && resolve[br_lane].taken) begin
        btb[resolve[br_lane].pc[5:2]] = resolve[br_lane].actual_target;
      end
      if (stim_done) begin
        done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/bp_assert.sv
`timescale 1ns/1ps
`default_nettype none

module bp_assert import bp_pkg::*; (
  input logic                        clock,
  input logic                        reset,
  input br_resolve_t [num_lanes-1:0] resolve,
  input ld_violate_t [num_lanes-1:0] violate,
  input fetch_redirect_t             redirect,
  input rollback_t                   rollback
);

  logic any_request;

  assign any_request = resolve[0].done || resolve[1].done ||
                       violate[0].violate || violate[1].violate;

  squash_on_rollback: assert property (@(posedge clock) disable iff (reset)
    rollback.en |-> redirect.lane_valid == 2'b00)
    else $error("fetch lane left valid during a rollback");

  // nothing past a taken lane 0
  lane1_after_taken: assert property (@(posedge clock) disable iff (reset)
    (!rollback.en && redirect.take_branch[0]) |-> !redirect.lane_valid[1])
    else $error("lane 1 valid behind a taken lane 0");

  quiet_without_request: assert property (@(posedge clock) disable iff (reset)
    !any_request |-> !rollback.en)
    else $error("rollback raised with no request present");

endmodule

bind branch_predictor bp_assert u_assert (
  .clock    (clock),
  .reset    (reset),
  .resolve  (resolve),
  .violate  (violate),
  .redirect (redirect),
  .rollback (rollback)
);

`default_nettype wire

// File: test/tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor import bp_pkg::*; ();

  localparam int num_cycles    = 3000;
  localparam int drain_timeout = 10;

  logic                        clock;
  logic                        reset;
  fetch_lane_t [num_lanes-1:0] lanes;
  br_resolve_t [num_lanes-1:0] resolve;
  ld_violate_t [num_lanes-1:0] violate;
  rob_idx_t                    rob_tail;
  fetch_redirect_t             redirect;
  rollback_t                   rollback;
  rob_idx_t                    rollback_distance;
  logic                        stim_done;
  logic                        check_done;
  logic                        drained;
  int                          check_errors;
  int                          tb_errors;
  integer                      seed;

  branch_predictor uut (.*);

  bp_checker u_checker (.done(check_done), .error_count(check_errors), .*);

  always #50 clock = ~clock;

  // sixteen table slots and bit 10 aliases two pcs onto each
  function automatic pc_t pool_pc(logic [4:0] r);
    return {20'h00001, 1'b0, r[4], 4'b0000, r[3:0], 2'b00};
  endfunction

  function automatic opcode_t pick_opcode(logic [4:0] r);
    opcode_t cond_ops [8];
    opcode_t jump_ops [4];
    cond_ops = '{blbc_op, beq_op, blt_op, ble_op, blbs_op, bne_op, bge_op, bgt_op};
    jump_ops = '{br_op, bsr_op, jsr_op, br_op};
    case (r[4:3])
      2'b00, 2'b01: return cond_ops[r[2:0]];
      2'b10:        return jump_ops[r[1:0]];
      default:      return {2'b00, r[3:0]};  // plain op that is never a branch
    endcase
  endfunction

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] s;
    pc_t         next_pc;
    for (int i = 0; i < num_lanes; i++) begin
      r = $random(seed);
      s = $random(seed);
      lanes[i].valid = r[31] | r[30];  // mostly valid
      lanes[i].pc    = pool_pc({r[11], r[29:26]});
      lanes[i].inst  = {pick_opcode(r[25:21]), s[25:0]};
      resolve[i].done          = r[0];
      resolve[i].taken         = r[1];
      resolve[i].pc            = pool_pc({r[12], r[7:4]});
      resolve[i].actual_target = {18'h00002, s[11:0], 2'b00};
      next_pc = r[1] ? resolve[i].actual_target : resolve[i].pc + 32'd4;
      // one in four goes the wrong way
      resolve[i].predicted_target = (r[3:2] == 2'b00) ? next_pc ^ 32'h10 : next_pc;
      resolve[i].rob_idx = s[16:12];
      resolve[i].fl_idx  = s[21:17];
      resolve[i].sq_idx  = s[24:22];
      resolve[i].lq_idx  = s[27:25];
      s = $random(seed);
      violate[i].violate    = (r[10:8] == 3'b000);
      violate[i].restart_pc = {18'h00003, s[11:0], 2'b00};
      violate[i].rob_idx    = s[16:12];
      violate[i].fl_idx     = s[21:17];
      violate[i].sq_idx     = s[24:22];
      violate[i].lq_idx     = s[27:25];
    end
    r = $random(seed);
    rob_tail = r[4:0];
  endtask

  initial begin
    seed      = 32'he72c;
    tb_errors = 0;
    clock     = 1'b0;
    reset     = 1'b1;
    stim_done = 1'b0;
    lanes     = '0;
    resolve   = '0;
    violate   = '0;
    rob_tail  = '0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int c = 0; c < num_cycles; c++) begin
      drive_inputs();
      @(negedge clock);
    end
    stim_done = 1'b1;
    drained   = 1'b0;
    for (int t = 0; t < drain_timeout && !drained; t++) begin
      @(negedge clock);
      drained = check_done;
    end
    if (!drained) begin
      $display("timeout while waiting for the checker to finish");
      tb_errors++;
    end
    $display("checker errors %0d, testbench errors %0d", check_errors, tb_errors);
    if (check_errors == 0 && tb_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
verilog/bp_pkg.sv
verilog/branch_decode.sv
verilog/branch_history_table.sv
verilog/branch_target_buffer.sv
verilog/rollback_arbiter.sv
verilog/branch_predictor.sv
test/bp_checker.sv
test/bp_assert.sv
test/tb_branch_predictor.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_branch_predictor
FILE_LIST = files.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
